// File: bpu.f
+incdir+verilog
verilog/bp_pkg.sv
verilog/branch_target_buffer.sv
verilog/branch_history_table.sv
verilog/branch_predictor.sv
test/tb_branch_predictor.sv

// File: test/tb_branch_predictor.sv
`include "bp_macros.svh"

module tb_branch_predictor
    import bp_pkg::*;
;

    localparam int RAND_CYCLES = 3000;             // length of the mixed random phase
    localparam int MAX_CYCLES  = 4000;             // directed + random + margin

    logic        s_clk;
    logic        rst_n;
    logic [30:0] fetch_add;                        // halfword fetch address
    logic        invalidate;
    bp_update_t  upd;
    bp_pred_t    pred;

    // reference state of both tables
    bit          ref_valid [`BP_BTB_ENTRIES];
    bit          ref_known [`BP_BTB_ENTRIES];      // entry data written at least once
    btb_entry_t  ref_mem   [`BP_BTB_ENTRIES];
    bht_cnt_t    ref_cnt   [`BP_BHT_ENTRIES];

    bp_pred_t    last_exp;                         // expected value of the latest cycle
    int          cycle_cnt = 0;

    branch_predictor dut0 (
        .s_clk_i        (s_clk),
        .rst_n_i        (rst_n),
        .fetch_add_i    (fetch_add),
        .invalidate_i   (invalidate),
        .upd_i          (upd),
        .pred_o         (pred)
    );

    initial begin
        s_clk = 1'b0;
        forever #2 s_clk = ~s_clk;                 // period 4
    end

    // run limit
    always @(posedge s_clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= MAX_CYCLES) begin
            $display("timeout: run did not finish within %0d cycles", MAX_CYCLES);
            $display("TB FAILED");
            $fatal(1, "run limit reached");
        end
    end

    // expected prediction worked out from the table rules
    function automatic bp_pred_t model_predict(input logic [30:0] f);
        bp_pred_t    p;
        btb_entry_t  e;
        logic [31:0] aligned;
        logic [31:0] off_sx;
        e       = ref_mem[f[`BP_TAG_W:1]];
        aligned = {f[30:1], 2'b00};                 // word aligned byte address
        off_sx  = {{(32-`BP_OFF_W){e.offset[`BP_OFF_W-1]}}, e.offset};
        p.pred_branch = ref_valid[f[`BP_TAG_W:1]]
                      && (e.base == f[30-`BP_SHARED:`BP_TAG_W+1])
                      && ref_cnt[f[`BP_HTAG_W:1]][1]
                      && (!f[0] || e.ualigc);
        p.ualigc      = e.ualigc;
        p.pred_add    = aligned + (e.ualigc ? 32'd2 : 32'd0) + (off_sx << 1);
        return p;
    endfunction

    // apply one cycle of strobes to the model
    task automatic model_update(input logic inv, input bp_update_t u);
        logic [`BP_TAG_W-1:0]  widx;
        logic [`BP_HTAG_W-1:0] hidx;
        widx = u.branch_add[`BP_TAG_W+1:2];
        hidx = u.branch_add[`BP_HTAG_W+1:2];
        if (u.branch_update) begin
            if (u.taken && ref_cnt[hidx] != 2'd3) begin
                ref_cnt[hidx] = ref_cnt[hidx] + 2'd1;
            end else if (!u.taken && ref_cnt[hidx] != 2'd0) begin
                ref_cnt[hidx] = ref_cnt[hidx] - 2'd1;
            end
            if (u.btb_update) begin
                ref_mem[widx].base   = u.branch_add[31-`BP_SHARED:`BP_TAG_W+2];
                ref_mem[widx].ualigc = u.ualigc;
                ref_mem[widx].offset = u.offset;
                ref_known[widx]      = 1'b1;
                ref_valid[widx]      = 1'b1;
            end
        end
        if (inv) begin
            ref_valid[widx] = 1'b0;                 // invalidate wins over the write
        end
    endtask

    // compares only the flag while the entry data is still unwritten
    task automatic check_pred(input bp_pred_t actual, input bp_pred_t expected,
                              input bit data_known);
        if (data_known && actual !== expected) begin
            $display("mismatch at %0t: pred_o got %h expected %h",
                     $time, actual, expected);
            $display("TB FAILED");
            $fatal(1, "prediction compare failed");
        end else if (!data_known && actual.pred_branch !== expected.pred_branch) begin
            $display("mismatch at %0t: pred_o.pred_branch got %b expected %b",
                     $time, actual.pred_branch, expected.pred_branch);
            $display("TB FAILED");
            $fatal(1, "prediction compare failed");
        end
    endtask

    // drive at the edge, check mid-cycle, then advance the model
    task automatic run_cycle(input logic [30:0] f, input logic inv, input bp_update_t u);
        @(posedge s_clk);
        fetch_add  <= f;
        invalidate <= inv;
        upd        <= u;
        @(negedge s_clk);
        last_exp = model_predict(f);
        check_pred(pred, last_exp, ref_known[f[`BP_TAG_W:1]]);
        model_update(inv, u);                      // takes effect at the next edge
    endtask

    function automatic bp_update_t make_upd(input logic [31:0] addr, input bit bu,
                                            input bit bt, input bit tk, input bit ua,
                                            input logic [`BP_OFF_W-1:0] off);
        bp_update_t u;
        u.branch_update = bu;
        u.btb_update    = bt;
        u.taken         = tk;
        u.ualigc        = ua;
        u.offset        = off;
        u.branch_add    = addr;
        return u;
    endfunction

    // quiet cycle plus a check that the scenario reached the intended state
    task automatic expect_hit(input logic [30:0] f, input bit exp);
        run_cycle(f, 1'b0, '0);
        if (last_exp.pred_branch != exp) begin
            $display("directed case at %0t expected pred_branch %b but reached %b",
                     $time, exp, last_exp.pred_branch);
            $display("TB FAILED");
            $fatal(1, "directed scenario went wrong");
        end
    endtask

    // narrow address pool with random shared bits, two tags, four indices and both halfwords
    function automatic logic [31:0] pool_addr();
        logic [31:0] a;
        a        = '0;
        a[31:24] = 8'($urandom);                   // aliased high bits
        a[23:6]  = 18'h02a40 + 18'($urandom % 2);
        a[5:2]   = 4'($urandom % 4);
        a[1]     = 1'($urandom % 2);               // odd halfword for rvc
        return a;
    endfunction

    initial begin
        logic [31:0] a_add;
        logic [31:0] b_add;
        logic [31:0] c_add;
        logic [31:0] r_add;
        bp_update_t  r_upd;
        void'($urandom(49));                       // seed once
        rst_n      = 1'b0;
        fetch_add  = '0;
        invalidate = 1'b0;
        upd        = '0;
        for (int i = 0; i < `BP_BTB_ENTRIES; i++) begin
            ref_valid[i] = 1'b0;
            ref_known[i] = 1'b0;
            ref_mem[i]   = '0;
        end
        for (int i = 0; i < `BP_BHT_ENTRIES; i++) begin
            ref_cnt[i] = 2'd0;
        end
        repeat (4) @(posedge s_clk);
        rst_n <= 1'b1;

        // nothing predicts out of reset
        for (int i = 0; i < 20; i++) begin
            expect_hit(31'($urandom), 1'b0);
        end

        // install, train twice and predict with both offset signs
        a_add = 32'h0004_0a48;
        run_cycle(a_add[31:1], 1'b0, make_upd(a_add, 1, 1, 1, 0, 12'h010));
        run_cycle(a_add[31:1], 1'b0, make_upd(a_add, 1, 0, 1, 0, 12'h000));
        expect_hit(a_add[31:1], 1'b1);
        run_cycle(a_add[31:1], 1'b0, make_upd(a_add, 1, 1, 1, 0, 12'hff0));
        expect_hit(a_add[31:1], 1'b1);             // negative offset target

        // counter sits at 3 when the saturation runs start
        for (int k = 1; k <= 5; k++) begin
            run_cycle(a_add[31:1], 1'b0, make_upd(a_add, 1, 0, 0, 0, 12'h000));
            expect_hit(a_add[31:1], k <= 1);        // 3-k still taken only for k=1
        end
        for (int k = 1; k <= 5; k++) begin
            run_cycle(a_add[31:1], 1'b0, make_upd(a_add, 1, 0, 1, 0, 12'h000));
            expect_hit(a_add[31:1], k >= 2);        // floor 0 then up
        end

        // invalidate, reinstall, invalidate together with a write
        run_cycle(a_add[31:1], 1'b1, make_upd(a_add, 0, 0, 0, 0, 12'h000));
        expect_hit(a_add[31:1], 1'b0);
        run_cycle(a_add[31:1], 1'b0, make_upd(a_add, 1, 1, 1, 0, 12'h030));
        expect_hit(a_add[31:1], 1'b1);
        run_cycle(a_add[31:1], 1'b1, make_upd(a_add, 1, 1, 1, 0, 12'h020));
        expect_hit(a_add[31:1], 1'b0);             // data written but entry invalid

        // unaligned rvc entry predicts on the odd halfword
        b_add = 32'h0004_0a56;
        run_cycle(b_add[31:1], 1'b0, make_upd(b_add, 1, 1, 1, 1, 12'h7f0));
        run_cycle(b_add[31:1], 1'b0, make_upd(b_add, 1, 0, 1, 1, 12'h000));
        expect_hit(b_add[31:1], 1'b1);
        expect_hit(b_add[31:1] ^ 31'h52800000, 1'b1);   // shared bits only
        expect_hit(b_add[31:1] ^ 31'h00000020, 1'b0);   // tag bit differs

        // aligned entry ignores the odd halfword
        c_add = 32'h0004_0a60;
        run_cycle(c_add[31:1], 1'b0, make_upd(c_add, 1, 1, 1, 0, 12'h800));
        run_cycle(c_add[31:1], 1'b0, make_upd(c_add, 1, 0, 1, 0, 12'h000));
        expect_hit(c_add[31:1], 1'b1);
        expect_hit(c_add[31:1] | 31'h1, 1'b0);

        // mixed random traffic against the model
        for (int i = 0; i < RAND_CYCLES; i++) begin
            r_add = pool_addr();
            r_upd = make_upd(r_add, ($urandom % 2) == 0, ($urandom % 2) == 0,
                             ($urandom % 10) < 6, r_add[1], 12'($urandom));
            run_cycle(31'(pool_addr() >> 1), ($urandom % 20) == 0, r_upd);
        end

        $display("TB PASSED");
        $finish;
    end

endmodule

// File: verilog/branch_predictor.sv
`include "bp_macros.svh"

module branch_predictor
    import bp_pkg::*;
(
    input  logic            s_clk_i,        // core clock
    input  logic            rst_n_i,        // clears btb valid bits and bht counters
    input  logic [30:0]     fetch_add_i,    // halfword address of the fetch
    input  logic            invalidate_i,   // drop the btb entry of upd_i.branch_add
    input  bp_update_t      upd_i,          // resolved branch from execute
    output bp_pred_t        pred_o          // same-cycle prediction
);

    // btb side
    logic [`BP_TAG_W-1:0]   btb_rd_idx;     // lookup index from the fetch address
    logic [`BP_TAG_W-1:0]   btb_wr_idx;     // install index from the branch address
    logic                   btb_we;         // install strobe
    logic                   btb_valid;      // looked-up entry is live
    btb_entry_t             btb_rentry;     // looked-up entry
    btb_entry_t             btb_wentry;     // entry being installed

    // bht side
    logic [`BP_HTAG_W-1:0]  bht_pred_idx;   // counter index for fetch
    logic [`BP_HTAG_W-1:0]  bht_upd_idx;    // counter index for training
    bht_cnt_t               bht_cnt;        // counter seen by fetch

    // prediction terms
    logic [`BP_BASE_W-1:0]  fetch_base;     // tag bits of the fetch address
    logic [`BP_BASE_W-1:0]  upd_base;       // tag bits of the branch address
    logic                   tag_hit;        // stored base matches fetch
    logic                   cnt_taken;      // counter leans taken
    logic                   align_ok;       // halfword position is consistent
    logic [31:0]            base_add;       // aligned fetch address, +2 for unaligned rvc
    logic [31:0]            off_add;        // offset in bytes, sign extended
    logic [31:0]            target_add;     // predicted target

    // index and tag slices, fetch works in halfwords and execute in bytes
    assign btb_rd_idx   = fetch_add_i[`BP_TAG_W:1];
    assign bht_pred_idx = fetch_add_i[`BP_HTAG_W:1];
    assign fetch_base   = fetch_add_i[30-`BP_SHARED:`BP_TAG_W+1];

    assign btb_wr_idx   = upd_i.branch_add[`BP_TAG_W+1:2];
    assign bht_upd_idx  = upd_i.branch_add[`BP_HTAG_W+1:2];
    assign upd_base     = upd_i.branch_add[31-`BP_SHARED:`BP_TAG_W+2];

    // a btb install only counts together with a branch update
    assign btb_we = upd_i.branch_update & upd_i.btb_update;

    // entry packed from the execute stage fields
    always_comb begin
        btb_wentry.base   = upd_base;
        btb_wentry.ualigc = upd_i.ualigc;
        btb_wentry.offset = upd_i.offset;
    end

    branch_target_buffer btb0 (
        .s_clk_i        (s_clk_i),
        .rst_n_i        (rst_n_i),
        .rd_idx_i       (btb_rd_idx),
        .wr_idx_i       (btb_wr_idx),
        .we_i           (btb_we),
        .invalidate_i   (invalidate_i),
        .wdata_i        (btb_wentry),
        .valid_o        (btb_valid),
        .entry_o        (btb_rentry)
    );

    branch_history_table bht0 (
        .s_clk_i        (s_clk_i),
        .rst_n_i        (rst_n_i),
        .pred_idx_i     (bht_pred_idx),
        .upd_idx_i      (bht_upd_idx),
        .upd_i          (upd_i.branch_update),
        .taken_i        (upd_i.taken),
        .cnt_o          (bht_cnt)
    );

    // hit needs a live entry, a matching tag, a taken counter and a legal halfword
    assign tag_hit   = (btb_rentry.base == fetch_base);
    assign cnt_taken = bht_cnt[1];                          // msb is the direction
    assign align_ok  = ~fetch_add_i[0] | btb_rentry.ualigc; // odd fetch needs rvc entry

    // the ualigc bit lands on byte address bit 1, which is the +2
    assign base_add = {fetch_add_i[30:1], btb_rentry.ualigc, 1'b0};
    assign off_add  = {{(32-`BP_OFF_W-1){btb_rentry.offset[`BP_OFF_W-1]}},
                       btb_rentry.offset, 1'b0};            // halfwords to bytes
    assign target_add = base_add + off_add;                 // single target adder

    // target and flag stay driven even without a hit
    always_comb begin
        pred_o.pred_branch = btb_valid & tag_hit & cnt_taken & align_ok;
        pred_o.ualigc      = btb_rentry.ualigc;
        pred_o.pred_add    = target_add;
    end

endmodule

// File: verilog/branch_history_table.sv
`include "bp_macros.svh"

module branch_history_table
    import bp_pkg::*;
(
    input  logic                    s_clk_i,        // core clock
    input  logic                    rst_n_i,        // clears every counter
    input  logic [`BP_HTAG_W-1:0]   pred_idx_i,     // counter read for fetch
    input  logic [`BP_HTAG_W-1:0]   upd_idx_i,      // counter trained by execute
    input  logic                    upd_i,          // branch resolved this cycle
    input  logic                    taken_i,        // resolved direction
    output bht_cnt_t                cnt_o           // counter at pred_idx_i
);

    bht_cnt_t cnt_q [`BP_BHT_ENTRIES];              // counter array
    bht_cnt_t upd_cnt;                              // current value at upd_idx_i
    bht_cnt_t upd_cnt_d;                            // trained value written back

    // second read port feeds the training logic
    assign upd_cnt = cnt_q[upd_idx_i];

    // saturating step toward the resolved direction
    always_comb begin
        if (taken_i) begin
            if (upd_cnt == BHT_STRONG_T) begin
                upd_cnt_d = BHT_STRONG_T;           // hold at the ceiling
            end else begin
                upd_cnt_d = upd_cnt + 2'd1;
            end
        end else begin
            if (upd_cnt == BHT_STRONG_NT) begin
                upd_cnt_d = BHT_STRONG_NT;          // hold at the floor
            end else begin
                upd_cnt_d = upd_cnt - 2'd1;
            end
        end
    end

    // counters start strongly not-taken
    always_ff @(posedge s_clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            for (int i = 0; i < `BP_BHT_ENTRIES; i++) begin
                cnt_q[i] <= BHT_STRONG_NT;
            end
        end else if (upd_i) begin
            cnt_q[upd_idx_i] <= upd_cnt_d;          // visible to fetch next cycle
        end
    end

    // prediction read port, old value on a same-cycle update
    assign cnt_o = cnt_q[pred_idx_i];

endmodule

// File: verilog/branch_target_buffer.sv
`include "bp_macros.svh"

module branch_target_buffer
    import bp_pkg::*;
(
    input  logic                    s_clk_i,        // core clock
    input  logic                    rst_n_i,        // clears every valid bit
    input  logic [`BP_TAG_W-1:0]    rd_idx_i,       // lookup index from fetch
    input  logic [`BP_TAG_W-1:0]    wr_idx_i,       // install/invalidate index
    input  logic                    we_i,           // write an entry
    input  logic                    invalidate_i,   // drop the entry at wr_idx_i
    input  btb_entry_t              wdata_i,        // entry to install
    output logic                    valid_o,        // entry at rd_idx_i is live
    output btb_entry_t              entry_o         // entry at rd_idx_i
);

    logic [`BP_BTB_ENTRIES-1:0] valid_q;            // one live bit per entry
    logic [`BP_BTB_ENTRIES-1:0] valid_d;            // next state of the live bits
    logic [`BP_BTB_ENTRIES-1:0] valid_sel;          // one-hot of wr_idx_i
    logic                       valid_we;           // live bits change this cycle

    logic [`BP_ENTRY_W-1:0]     mem_q [`BP_BTB_ENTRIES];    // entry storage, no reset

    // one-hot select of the entry being touched
    assign valid_sel = {{(`BP_BTB_ENTRIES-1){1'b0}}, 1'b1} << wr_idx_i;

    // both strobes touch the live bits
    assign valid_we = invalidate_i | we_i;

    // invalidate takes priority over a write in the same cycle
    always_comb begin
        if (invalidate_i) begin
            valid_d = valid_q & ~valid_sel;         // clear the selected bit
        end else begin
            valid_d = valid_q | valid_sel;          // mark the new entry live
        end
    end

    always_ff @(posedge s_clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            valid_q <= '0;                          // nothing predicts after reset
        end else if (valid_we) begin
            valid_q <= valid_d;
        end
    end

    // entry data is written even when the same cycle invalidates it
    always_ff @(posedge s_clk_i) begin
        if (we_i) begin
            mem_q[wr_idx_i] <= wdata_i;             // flat copy of the struct
        end
    end

    // combinational read port, same-cycle writes are not forwarded
    assign valid_o = valid_q[rd_idx_i];
    assign entry_o = btb_entry_t'(mem_q[rd_idx_i]);

endmodule

// File: verilog/bp_pkg.sv
`include "bp_macros.svh"

package bp_pkg;

    // update from the execute stage, one per resolved branch
    typedef struct packed {
        logic                   branch_update;  // branch resolved this cycle
        logic                   btb_update;     // also install the target in the btb
        logic                   taken;          // condition was met
        logic                   ualigc;         // unaligned compressed branch
        logic [`BP_OFF_W-1:0]   offset;         // target offset in halfwords, signed
        logic [31:0]            branch_add;     // byte address of the branch
    } bp_update_t;

    // prediction handed back to fetch
    typedef struct packed {
        logic                   pred_branch;    // predicted taken and known target
        logic                   ualigc;         // stored entry is an unaligned rvc branch
        logic [31:0]            pred_add;       // predicted target byte address
    } bp_pred_t;

    // one stored btb entry
    typedef struct packed {
        logic [`BP_BASE_W-1:0]  base;           // partial tag of the branch address
        logic                   ualigc;         // branch sits on an odd halfword
        logic [`BP_OFF_W-1:0]   offset;         // halfword offset to the target
    } btb_entry_t;

    // saturating counter, msb set means predict taken
    typedef logic [1:0] bht_cnt_t;

    // counter encodings
    localparam bht_cnt_t BHT_STRONG_NT = 2'd0;  // floor of the counter
    localparam bht_cnt_t BHT_STRONG_T  = 2'd3;  // ceiling of the counter

endpackage

// File: verilog/bp_macros.svh
`ifndef BP_MACROS_SVH
`define BP_MACROS_SVH

// table sizes
`define BP_BTB_ENTRIES 16               // entries in the branch target buffer
`define BP_BHT_ENTRIES 16               // two-bit counters in the history table

// high address bits left out of the tag, aliasing on purpose
`define BP_SHARED 8

// branch offset as carried by the execute stage, in halfwords
`define BP_OFF_W 12

// derived index widths
`define BP_TAG_W ($clog2(`BP_BTB_ENTRIES))      // btb index bits
`define BP_HTAG_W ($clog2(`BP_BHT_ENTRIES))     // bht index bits

// stored tag, word address minus index and shared bits
`define BP_BASE_W (32 - `BP_TAG_W - 2 - `BP_SHARED)

// one btb entry as a flat word: base, ualigc flag, offset
`define BP_ENTRY_W (`BP_BASE_W + 1 + `BP_OFF_W)

`endif
